// File: cp0_consts.svh
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

// cp0 register numbers
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15
`define CP0_REG_CONFIG   5'd16

// cause.exccode values
`define EXC_CODE_INT     5'd0
`define EXC_CODE_ADEL    5'd4
`define EXC_CODE_ADES    5'd5
`define EXC_CODE_SYS     5'd8
`define EXC_CODE_BP      5'd9
`define EXC_CODE_RI      5'd10
`define EXC_CODE_OV      5'd12

// reset values, BEV set in status
`define STATUS_RESET     32'h0040_0000
`define CONFIG_RESET     32'h0000_8000
`define PRID_RESET       32'h004c_0102

// software-writable fields
`define STATUS_WMASK     32'h0000_ff01
`define CAUSE_WMASK      32'h0000_0300

// general exception entry
`define EXC_VECTOR       32'hbfc0_0380

`endif

// File: cp0_pkg.sv
`default_nettype none

package cp0_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_num_t;
   typedef logic [4:0]  exc_code_t;
   typedef logic [5:0]  int_vec_t;

   // wishbone slave handshake
   typedef enum logic [1:0] {
      WB_IDLE,
      WB_ACK,
      WB_DONE
   } wb_state_t;

endpackage

`default_nettype wire

// File: exc_if.sv
`timescale 1ns/1ns
`default_nettype none

interface exc_if;
   import cp0_pkg::*;

   logic      commit;
   logic      is_eret;
   exc_code_t code;
   word_t     epc;
   logic      bd;
   word_t     badvaddr;
   logic      badvaddr_we;

   modport src (output commit, is_eret, code, epc, bd, badvaddr, badvaddr_we);
   modport dst (input commit, is_eret, code, epc, bd, badvaddr, badvaddr_we);

endinterface

`default_nettype wire

// File: exc_prioritizer.sv
`timescale 1ns/1ns
`default_nettype none

`include "cp0_consts.svh"

module exc_prioritizer (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  inst_valid_i,
   input  wire                  in_delay_slot_i,
   input  wire                  fetch_adel_i,
   input  wire                  ri_i,
   input  wire                  ov_i,
   input  wire                  sys_i,
   input  wire                  bp_i,
   input  wire                  data_adel_i,
   input  wire                  ades_i,
   input  wire                  eret_i,
   input  wire cp0_pkg::word_t  inst_pc_i,
   input  wire cp0_pkg::word_t  mem_addr_i,
   input  wire cp0_pkg::word_t  status_i,
   input  wire cp0_pkg::word_t  cause_i,
   input  wire cp0_pkg::word_t  epc_i,
   exc_if.src                   exc_o,
   output logic                 exc_taken_o,
   output cp0_pkg::word_t       exc_pc_o
);
   import cp0_pkg::*;

   logic      exl_eff;
   logic      int_pend;
   logic      take_exc;
   logic      take_eret;
   logic      badv_we;
   exc_code_t code;
   word_t     badv;
   word_t     epc_rec;

   // an exception still in flight has not set EXL yet
   assign exl_eff  = status_i[1] | (exc_o.commit & ~exc_o.is_eret);
   assign int_pend = status_i[0] & (|(cause_i[15:8] & status_i[15:8]));

   always_comb begin
      take_exc = 1'b0;
      code     = `EXC_CODE_INT;
      badv_we  = 1'b0;
      badv     = mem_addr_i;
      if (inst_valid_i && !exl_eff) begin
         take_exc = 1'b1;
         if (int_pend) begin
            code = `EXC_CODE_INT;
         end else if (fetch_adel_i) begin
            code    = `EXC_CODE_ADEL;
            badv_we = 1'b1;
            badv    = inst_pc_i;
         end else if (ri_i) begin
            code = `EXC_CODE_RI;
         end else if (ov_i) begin
            code = `EXC_CODE_OV;
         end else if (sys_i) begin
            code = `EXC_CODE_SYS;
         end else if (bp_i) begin
            code = `EXC_CODE_BP;
         end else if (data_adel_i) begin
            code    = `EXC_CODE_ADEL;
            badv_we = 1'b1;
         end else if (ades_i) begin
            code    = `EXC_CODE_ADES;
            badv_we = 1'b1;
         end else begin
            take_exc = 1'b0;
         end
      end
   end

   // eret is lowest priority but still allowed under EXL
   assign take_eret = inst_valid_i & eret_i & ~take_exc;
   assign epc_rec   = in_delay_slot_i ? inst_pc_i - 32'd4 : inst_pc_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         exc_o.commit <= 1'b0;
      end else begin
         exc_o.commit <= take_exc | take_eret;
      end
   end

   always_ff @(posedge clk) begin
      exc_o.is_eret     <= take_eret;
      exc_o.code        <= code;
      exc_o.epc         <= epc_rec;
      exc_o.bd          <= in_delay_slot_i;
      exc_o.badvaddr    <= badv;
      exc_o.badvaddr_we <= badv_we;
      exc_pc_o          <= take_eret ? epc_i : `EXC_VECTOR;
   end

   assign exc_taken_o = exc_o.commit;

endmodule

`default_nettype wire

// File: cp0_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "cp0_consts.svh"

module cp0_regfile (
   input  wire                    clk,
   input  wire                    rst,
   input  wire cp0_pkg::int_vec_t hw_int_i,
   exc_if.dst                     exc_i,
   input  wire                    wr_en_i,
   input  wire cp0_pkg::reg_num_t wr_num_i,
   input  wire cp0_pkg::reg_num_t rd_num_i,
   input  wire cp0_pkg::word_t    wr_data_i,
   output cp0_pkg::word_t         rd_data_o,
   output cp0_pkg::word_t         status_o,
   output cp0_pkg::word_t         cause_o,
   output cp0_pkg::word_t         epc_o,
   output logic                   timer_int_o
);
   import cp0_pkg::*;

   word_t    count_q;
   word_t    compare_q;
   word_t    status_q;
   word_t    cause_q;
   word_t    epc_q;
   word_t    badvaddr_q;
   int_vec_t hw_int_q;
   logic     timer_q;
   int_vec_t ip_hw;

   always_ff @(posedge clk) begin
      if (rst) begin
         count_q   <= '0;
         compare_q <= '0;
         status_q  <= `STATUS_RESET;
         cause_q   <= '0;
         hw_int_q  <= '0;
         timer_q   <= 1'b0;
      end else begin
         count_q  <= count_q + 32'd1;
         hw_int_q <= hw_int_i;
         if (compare_q != '0 && count_q == compare_q) begin
            timer_q <= 1'b1;
         end
         if (wr_en_i) begin
            case (wr_num_i)
               `CP0_REG_COUNT: begin
                  count_q <= wr_data_i;
               end
               `CP0_REG_COMPARE: begin
                  compare_q <= wr_data_i;
                  timer_q   <= 1'b0;
               end
               `CP0_REG_STATUS: begin
                  status_q <= (status_q & ~`STATUS_WMASK) | (wr_data_i & `STATUS_WMASK);
               end
               `CP0_REG_CAUSE: begin
                  cause_q <= (cause_q & ~`CAUSE_WMASK) | (wr_data_i & `CAUSE_WMASK);
               end
               default: begin
               end
            endcase
         end
         // commit comes last so it beats a same-edge bus write
         if (exc_i.commit) begin
            if (exc_i.is_eret) begin
               status_q[1] <= 1'b0;
            end else begin
               status_q[1]   <= 1'b1;
               cause_q[31]   <= exc_i.bd;
               cause_q[6:2]  <= exc_i.code;
            end
         end
      end
   end

   // a commit overrides a bus write to epc
   always_ff @(posedge clk) begin
      if (wr_en_i && wr_num_i == `CP0_REG_EPC) begin
         epc_q <= wr_data_i;
      end
      if (exc_i.commit && !exc_i.is_eret) begin
         epc_q <= exc_i.epc;
         if (exc_i.badvaddr_we) begin
            badvaddr_q <= exc_i.badvaddr;
         end
      end
   end

   // timer shares IP7 with hw line 5
   assign ip_hw = {hw_int_q[5] | timer_q, hw_int_q[4:0]};

   assign status_o    = status_q;
   assign cause_o     = (cause_q & 32'hffff_03ff) | {16'b0, ip_hw, 10'b0};
   assign epc_o       = epc_q;
   assign timer_int_o = timer_q;

   always_comb begin
      case (rd_num_i)
         `CP0_REG_BADVADDR: rd_data_o = badvaddr_q;
         `CP0_REG_COUNT:    rd_data_o = count_q;
         `CP0_REG_COMPARE:  rd_data_o = compare_q;
         `CP0_REG_STATUS:   rd_data_o = status_o;
         `CP0_REG_CAUSE:    rd_data_o = cause_o;
         `CP0_REG_EPC:      rd_data_o = epc_q;
         `CP0_REG_PRID:     rd_data_o = `PRID_RESET;
         `CP0_REG_CONFIG:   rd_data_o = `CONFIG_RESET;
         default:           rd_data_o = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: cp0_wb_slave.sv
`timescale 1ns/1ns
`default_nettype none

module cp0_wb_slave (
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    wb_cyc_i,
   input  wire                    wb_stb_i,
   input  wire                    wb_we_i,
   input  wire cp0_pkg::reg_num_t wb_adr_i,
   input  wire cp0_pkg::word_t    wb_dat_i,
   output cp0_pkg::word_t         wb_dat_o,
   output logic                   wb_ack_o,
   output logic                   wr_en_o,
   output cp0_pkg::reg_num_t      wr_num_o,
   output cp0_pkg::reg_num_t      rd_num_o,
   output cp0_pkg::word_t         wr_data_o,
   input  wire cp0_pkg::word_t    rd_data_i
);
   import cp0_pkg::*;

   wb_state_t state;
   logic      req;
   logic      we_q;

   assign req = wb_cyc_i & wb_stb_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= WB_IDLE;
      end else begin
         case (state)
            WB_IDLE: if (req) state <= WB_ACK;
            WB_ACK:  state <= WB_DONE;
            // hold off until the master drops stb
            WB_DONE: if (!req) state <= WB_IDLE;
            default: state <= WB_IDLE;
         endcase
      end
   end

   // request fields and read data captured together
   always_ff @(posedge clk) begin
      if (state == WB_IDLE && req) begin
         we_q      <= wb_we_i;
         wr_num_o  <= wb_adr_i;
         wr_data_o <= wb_dat_i;
         wb_dat_o  <= rd_data_i;
      end
   end

   assign rd_num_o = wb_adr_i;
   assign wb_ack_o = (state == WB_ACK);
   assign wr_en_o  = (state == WB_ACK) & we_q;

endmodule

`default_nettype wire

// File: cp0_top.sv
`timescale 1ns/1ns
`default_nettype none

module cp0_top (
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    wb_cyc_i,
   input  wire                    wb_stb_i,
   input  wire                    wb_we_i,
   input  wire cp0_pkg::reg_num_t wb_adr_i,
   input  wire cp0_pkg::word_t    wb_dat_i,
   output cp0_pkg::word_t         wb_dat_o,
   output logic                   wb_ack_o,
   input  wire                    inst_valid_i,
   input  wire cp0_pkg::word_t    inst_pc_i,
   input  wire                    in_delay_slot_i,
   input  wire                    fetch_adel_i,
   input  wire                    ri_i,
   input  wire                    ov_i,
   input  wire                    sys_i,
   input  wire                    bp_i,
   input  wire                    data_adel_i,
   input  wire                    ades_i,
   input  wire cp0_pkg::word_t    mem_addr_i,
   input  wire                    eret_i,
   input  wire cp0_pkg::int_vec_t hw_int_i,
   output logic                   exc_taken_o,
   output cp0_pkg::word_t         exc_pc_o,
   output logic                   timer_int_o
);
   import cp0_pkg::*;

   word_t    status;
   word_t    cause;
   word_t    epc;
   word_t    rd_data;
   word_t    wr_data;
   reg_num_t wr_num;
   reg_num_t rd_num;
   logic     wr_en;

   exc_if exc_bus ();

   exc_prioritizer u_prio (
      .clk             (clk),
      .rst             (rst),
      .inst_valid_i    (inst_valid_i),
      .in_delay_slot_i (in_delay_slot_i),
      .fetch_adel_i    (fetch_adel_i),
      .ri_i            (ri_i),
      .ov_i            (ov_i),
      .sys_i           (sys_i),
      .bp_i            (bp_i),
      .data_adel_i     (data_adel_i),
      .ades_i          (ades_i),
      .eret_i          (eret_i),
      .inst_pc_i       (inst_pc_i),
      .mem_addr_i      (mem_addr_i),
      .status_i        (status),
      .cause_i         (cause),
      .epc_i           (epc),
      .exc_o           (exc_bus.src),
      .exc_taken_o     (exc_taken_o),
      .exc_pc_o        (exc_pc_o)
   );

   cp0_regfile u_regs (
      .clk         (clk),
      .rst         (rst),
      .hw_int_i    (hw_int_i),
      .exc_i       (exc_bus.dst),
      .wr_en_i     (wr_en),
      .wr_num_i    (wr_num),
      .rd_num_i    (rd_num),
      .wr_data_i   (wr_data),
      .rd_data_o   (rd_data),
      .status_o    (status),
      .cause_o     (cause),
      .epc_o       (epc),
      .timer_int_o (timer_int_o)
   );

   cp0_wb_slave u_wb (
      .clk       (clk),
      .rst       (rst),
      .wb_cyc_i  (wb_cyc_i),
      .wb_stb_i  (wb_stb_i),
      .wb_we_i   (wb_we_i),
      .wb_adr_i  (wb_adr_i),
      .wb_dat_i  (wb_dat_i),
      .wb_dat_o  (wb_dat_o),
      .wb_ack_o  (wb_ack_o),
      .wr_en_o   (wr_en),
      .wr_num_o  (wr_num),
      .rd_num_o  (rd_num),
      .wr_data_o (wr_data),
      .rd_data_i (rd_data)
   );

endmodule

`default_nettype wire

// File: tb_cp0_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "cp0_consts.svh"

module tb_cp0_top;
   import cp0_pkg::*;

   localparam int N_EXC = 24;
   localparam int N_INT = 12;
   // register sweep, exception rounds, interrupt rounds, timer wait and setup
   localparam int PLANNED = 64 + 8 * N_EXC + 8 * N_INT + 80 + 10;
   localparam int TIMEOUT_CYCLES = 20 * PLANNED;

   logic      clk;
   logic      rst;
   logic      wb_cyc;
   logic      wb_stb;
   logic      wb_we;
   reg_num_t  wb_adr;
   word_t     wb_dat_w;
   word_t     wb_dat_r;
   logic      wb_ack;
   logic      inst_valid;
   word_t     inst_pc;
   logic      in_delay_slot;
   logic      fetch_adel;
   logic      ri;
   logic      ov;
   logic      sys;
   logic      bp;
   logic      data_adel;
   logic      ades;
   word_t     mem_addr;
   logic      eret;
   int_vec_t  hw_int;
   logic      exc_taken;
   word_t     exc_pc;
   logic      timer_int;
   int        cycle_count = 0;

   // reference model state
   word_t     m_status;
   logic      [1:0] m_cause_sw;
   logic      m_bd;
   exc_code_t m_code;
   word_t     m_epc;
   word_t     m_badv;
   logic      m_badv_valid;
   word_t     m_compare;

   cp0_top u_dut (
      .clk             (clk),
      .rst             (rst),
      .wb_cyc_i        (wb_cyc),
      .wb_stb_i        (wb_stb),
      .wb_we_i         (wb_we),
      .wb_adr_i        (wb_adr),
      .wb_dat_i        (wb_dat_w),
      .wb_dat_o        (wb_dat_r),
      .wb_ack_o        (wb_ack),
      .inst_valid_i    (inst_valid),
      .inst_pc_i       (inst_pc),
      .in_delay_slot_i (in_delay_slot),
      .fetch_adel_i    (fetch_adel),
      .ri_i            (ri),
      .ov_i            (ov),
      .sys_i           (sys),
      .bp_i            (bp),
      .data_adel_i     (data_adel),
      .ades_i          (ades),
      .mem_addr_i      (mem_addr),
      .eret_i          (eret),
      .hw_int_i        (hw_int),
      .exc_taken_o     (exc_taken),
      .exc_pc_o        (exc_pc),
      .timer_int_o     (timer_int)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
         $display("Simulation failed");
         $fatal(1, "timeout");
      end
   end

   task automatic check_value(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic word_t rand_word();
      return $urandom;
   endfunction

   // ip field has hw lines and timer at 15:10 and sw bits at 9:8
   function automatic word_t exp_cause(input int_vec_t hw, input logic tmr);
      logic [7:0] ip;
      ip = {hw[5] | tmr, hw[4:0], m_cause_sw};
      return {m_bd, 15'b0, ip, 1'b0, m_code, 2'b00};
   endfunction

   function automatic word_t exp_reg(input reg_num_t num);
      case (num)
         `CP0_REG_COMPARE: return m_compare;
         `CP0_REG_STATUS:  return m_status;
         `CP0_REG_CAUSE:   return exp_cause(6'b0, 1'b0);
         `CP0_REG_EPC:     return m_epc;
         `CP0_REG_PRID:    return `PRID_RESET;
         `CP0_REG_CONFIG:  return `CONFIG_RESET;
         default:          return 32'h0;
      endcase
   endfunction

   function automatic exc_code_t priority_code(input logic [6:0] flags);
      if (flags[0]) return `EXC_CODE_ADEL;
      else if (flags[1]) return `EXC_CODE_RI;
      else if (flags[2]) return `EXC_CODE_OV;
      else if (flags[3]) return `EXC_CODE_SYS;
      else if (flags[4]) return `EXC_CODE_BP;
      else if (flags[5]) return `EXC_CODE_ADEL;
      else return `EXC_CODE_ADES;
   endfunction

   task automatic model_write(input reg_num_t num, input word_t dat);
      case (num)
         `CP0_REG_STATUS:  m_status = (m_status & ~`STATUS_WMASK) | (dat & `STATUS_WMASK);
         `CP0_REG_CAUSE:   m_cause_sw = dat[9:8];
         `CP0_REG_EPC:     m_epc = dat;
         `CP0_REG_COMPARE: m_compare = dat;
         default: ;
      endcase
   endtask

   task automatic model_exception(input word_t pc, input logic ds, input exc_code_t code,
                                  input logic [6:0] flags, input word_t addr);
      m_epc = ds ? pc - 32'd4 : pc;
      m_bd = ds;
      m_code = code;
      m_status[1] = 1'b1;
      if (flags[0]) begin
         m_badv = pc;
         m_badv_valid = 1'b1;
      end else if (code == `EXC_CODE_ADEL || code == `EXC_CODE_ADES) begin
         m_badv = addr;
         m_badv_valid = 1'b1;
      end
   endtask

   task automatic wb_write(input reg_num_t adr, input word_t dat);
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= 1'b1;
      wb_adr <= adr;
      wb_dat_w <= dat;
      do @(negedge clk); while (!wb_ack);
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we <= 1'b0;
      model_write(adr, dat);
      @(negedge clk);
      check_value("wb_ack_o", {31'b0, wb_ack}, 32'd0);
   endtask

   task automatic wb_read(input reg_num_t adr, output word_t dat);
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we <= 1'b0;
      wb_adr <= adr;
      do @(negedge clk); while (!wb_ack);
      dat = wb_dat_r;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      @(negedge clk);
      check_value("wb_ack_o", {31'b0, wb_ack}, 32'd0);
   endtask

   task automatic read_check(input string name, input reg_num_t adr, input word_t exp);
      word_t dat;
      wb_read(adr, dat);
      check_value(name, dat, exp);
   endtask

   // one instruction in the commit stage and its redirect a cycle later
   task automatic issue_event(input word_t pc, input logic ds, input logic [6:0] flags,
                              input word_t addr, input logic is_eret,
                              output logic taken, output word_t redirect);
      @(posedge clk);
      inst_valid <= 1'b1;
      inst_pc <= pc;
      in_delay_slot <= ds;
      {ades, data_adel, bp, sys, ov, ri, fetch_adel} <= flags;
      mem_addr <= addr;
      eret <= is_eret;
      @(posedge clk);
      inst_valid <= 1'b0;
      {ades, data_adel, bp, sys, ov, ri, fetch_adel} <= 7'b0;
      eret <= 1'b0;
      @(negedge clk);
      taken = exc_taken;
      redirect = exc_pc;
      @(posedge clk);
   endtask

   task automatic do_eret();
      logic  taken;
      word_t redirect;
      issue_event(rand_word(), 1'b0, 7'b0, 32'h0, 1'b1, taken, redirect);
      check_value("exc_taken_o", {31'b0, taken}, 32'd1);
      check_value("exc_pc_o", redirect, m_epc);
      m_status[1] = 1'b0;
      read_check("status", `CP0_REG_STATUS, m_status);
   endtask

   initial begin
      word_t      r;
      word_t      pc;
      word_t      addr;
      word_t      cnt_a;
      word_t      cnt_b;
      logic       ds;
      logic       taken;
      logic       pend;
      logic [6:0] flags;
      int_vec_t   hw;
      word_t      redirect;
      exc_code_t  code;

      void'($urandom(32'ha59e_a1ae));
      rst = 1'b1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
      wb_adr = '0;
      wb_dat_w = '0;
      inst_valid = 1'b0;
      inst_pc = '0;
      in_delay_slot = 1'b0;
      {ades, data_adel, bp, sys, ov, ri, fetch_adel} = 7'b0;
      mem_addr = '0;
      eret = 1'b0;
      hw_int = '0;
      m_status = `STATUS_RESET;
      m_cause_sw = 2'b0;
      m_bd = 1'b0;
      m_code = '0;
      m_epc = '0;
      m_badv = '0;
      m_badv_valid = 1'b0;
      m_compare = '0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;

      // register sweep that skips count and the still unset badvaddr
      for (int i = 0; i < 32; i++) begin
         if (5'(i) != `CP0_REG_COUNT) begin
            wb_write(5'(i), rand_word());
         end
      end
      for (int i = 0; i < 32; i++) begin
         if (5'(i) != `CP0_REG_COUNT && 5'(i) != `CP0_REG_BADVADDR) begin
            read_check("wb_dat_o", 5'(i), exp_reg(5'(i)));
         end
      end

      wb_write(`CP0_REG_STATUS, 32'h0);
      wb_write(`CP0_REG_CAUSE, 32'h0);
      wb_write(`CP0_REG_COMPARE, 32'h0);

      // synchronous exceptions each followed by a blocked event and eret
      for (int n = 0; n < N_EXC; n++) begin
         r = rand_word();
         flags = r[6:0];
         if (flags == 7'b0) begin
            r = rand_word() % 32'd7;
            flags = 7'd1 << r[2:0];
         end
         pc = rand_word();
         addr = rand_word();
         r = rand_word();
         ds = r[0];
         code = priority_code(flags);
         issue_event(pc, ds, flags, addr, 1'b0, taken, redirect);
         check_value("exc_taken_o", {31'b0, taken}, 32'd1);
         check_value("exc_pc_o", redirect, `EXC_VECTOR);
         model_exception(pc, ds, code, flags, addr);
         read_check("epc", `CP0_REG_EPC, m_epc);
         read_check("cause", `CP0_REG_CAUSE, exp_cause(6'b0, 1'b0));
         read_check("status", `CP0_REG_STATUS, m_status);
         if (m_badv_valid) begin
            read_check("badvaddr", `CP0_REG_BADVADDR, m_badv);
         end
         issue_event(rand_word(), 1'b0, 7'h02, 32'h0, 1'b0, taken, redirect);
         check_value("exc_taken_o", {31'b0, taken}, 32'd0);
         do_eret();
      end

      // hardware interrupt lines against IE and IM
      for (int n = 0; n < N_INT; n++) begin
         r = rand_word();
         hw = r[5:0] | 6'b1;
         wb_write(`CP0_REG_STATUS, {16'b0, r[15:8], 7'b0, r[16]});
         pend = r[16] & (|({hw, 2'b00} & r[15:8]));
         @(posedge clk);
         hw_int <= hw;
         repeat (2) @(posedge clk);
         pc = rand_word();
         issue_event(pc, 1'b0, 7'b0, 32'h0, 1'b0, taken, redirect);
         check_value("exc_taken_o", {31'b0, taken}, {31'b0, pend});
         if (pend) begin
            check_value("exc_pc_o", redirect, `EXC_VECTOR);
            model_exception(pc, 1'b0, `EXC_CODE_INT, 7'b0, 32'h0);
         end
         read_check("cause", `CP0_REG_CAUSE, exp_cause(hw, 1'b0));
         if (pend) begin
            do_eret();
         end
         @(posedge clk);
         hw_int <= '0;
         repeat (2) @(posedge clk);
      end
      wb_write(`CP0_REG_STATUS, 32'h0);

      // count/compare timer
      wb_read(`CP0_REG_COUNT, cnt_a);
      wb_write(`CP0_REG_COMPARE, cnt_a + 32'd40);
      for (int i = 0; i < 60; i++) begin
         @(negedge clk);
         if (timer_int) break;
      end
      check_value("timer_int_o", {31'b0, timer_int}, 32'd1);
      read_check("cause", `CP0_REG_CAUSE, exp_cause(6'b0, 1'b1));
      wb_write(`CP0_REG_COMPARE, 32'h0);
      @(negedge clk);
      check_value("timer_int_o", {31'b0, timer_int}, 32'd0);

      wb_read(`CP0_REG_COUNT, cnt_a);
      wb_read(`CP0_REG_COUNT, cnt_b);
      check_value("count_increase", {31'b0, cnt_b > cnt_a}, 32'd1);

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
cp0_pkg.sv
exc_if.sv
exc_prioritizer.sv
cp0_regfile.sv
cp0_wb_slave.sv
cp0_top.sv
tb_cp0_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cp0_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
